// ==== include/tower_settings.svh ====
`ifndef TOWER_SETTINGS_SVH
`define TOWER_SETTINGS_SVH

// Word widths
`define TOWER_COORD_W 10
`define TOWER_COLOR_W 4

// Screen and margins
`define TOWER_H_ACTIVE 640
`define TOWER_V_ACTIVE 480
`define TOWER_SIDE_BUF 20
`define TOWER_TOP_BUF  15

// Floors and cab
`define TOWER_FLOOR_H      75
`define TOWER_HALF_FLOOR_H 37
`define TOWER_CAB_H        70
`define TOWER_TOP_LEVEL    10

// Column edges, each the first x of its span
`define TOWER_LEFT_SHAFT_X0    210
`define TOWER_MID_OUTLINE_X0   295
`define TOWER_RIGHT_SHAFT_X0   305
`define TOWER_RIGHT_OUTLINE_X0 395
`define TOWER_RIGHT_BLDG_X0    405

// Stop marker, inclusive bounds
`define TOWER_STOP_X0 300
`define TOWER_STOP_X1 339
`define TOWER_STOP_Y0 200
`define TOWER_STOP_Y1 259

// Colours as {r, g, b}
`define TOWER_SKY_RGB         12'h28F
`define TOWER_DARK_FLOOR_RGB  12'h9AA
`define TOWER_LIGHT_FLOOR_RGB 12'hBBB
`define TOWER_SHAFT_RGB       12'h841
`define TOWER_CAB_RGB         12'h444
`define TOWER_RED_RGB         12'hF00
`define TOWER_GRASS_RGB       12'h0F0
`define TOWER_BLACK_RGB       12'h000

`endif

// ==== logic/tower_pkg.sv ====
`default_nettype none

`include "tower_settings.svh"

package tower_pkg;

    typedef logic [`TOWER_COORD_W-1:0] coord_t;
    typedef logic [`TOWER_COLOR_W-1:0] color_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } pixel_pos_t;

    typedef struct packed {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    typedef enum logic [2:0] {
        BLANK,
        SKY,
        FLOOR_DARK,
        FLOOR_LIGHT,
        OUTLINE,
        LEFT_SHAFT,
        RIGHT_SHAFT,
        GRASS
    } region_e;

    // Codes 2 and 3 both mean stop
    typedef enum logic [1:0] {
        SIM_IDLE = 2'd0,
        SIM_RUN  = 2'd1,
        SIM_STOP = 2'd2
    } sim_state_e;

    typedef struct packed {
        logic [3:0] left_level;
        logic [3:0] right_level;
    } dest_levels_t;

    localparam rgb_t SKY_RGB         = `TOWER_SKY_RGB;
    localparam rgb_t DARK_FLOOR_RGB  = `TOWER_DARK_FLOOR_RGB;
    localparam rgb_t LIGHT_FLOOR_RGB = `TOWER_LIGHT_FLOOR_RGB;
    localparam rgb_t SHAFT_RGB       = `TOWER_SHAFT_RGB;
    localparam rgb_t CAB_RGB         = `TOWER_CAB_RGB;
    localparam rgb_t RED_RGB         = `TOWER_RED_RGB;
    localparam rgb_t GRASS_RGB       = `TOWER_GRASS_RGB;
    localparam rgb_t BLACK_RGB       = `TOWER_BLACK_RGB;

endpackage

`default_nettype wire

// ==== logic/backdrop_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tower_settings.svh"

module backdrop_classifier
    import tower_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire logic       enable,
    input  wire pixel_pos_t pos,
    output region_e         region
);

    logic    side_sky;
    logic    in_frame_rows;
    logic    in_left_bldg;
    logic    in_right_bldg;
    logic    in_outline;
    logic    in_left_shaft;
    logic    in_right_shaft;
    coord_t  floor_rel;
    coord_t  floor_band;
    region_e region_d;

    // Right margin stops above the grass strip, left margin runs full height
    assign side_sky = (pos.x < `TOWER_SIDE_BUF) ||
                      (pos.x >= `TOWER_H_ACTIVE - `TOWER_SIDE_BUF &&
                       pos.x < `TOWER_H_ACTIVE &&
                       pos.y < `TOWER_V_ACTIVE - `TOWER_TOP_BUF);

    assign in_frame_rows = pos.y >= `TOWER_TOP_BUF &&
                           pos.y < `TOWER_V_ACTIVE - `TOWER_TOP_BUF;

    assign in_left_bldg  = pos.x >= `TOWER_SIDE_BUF && pos.x < `TOWER_LEFT_SHAFT_X0;
    assign in_right_bldg = pos.x >= `TOWER_RIGHT_BLDG_X0 &&
                           pos.x < `TOWER_H_ACTIVE - `TOWER_SIDE_BUF;

    assign in_outline = in_frame_rows &&
                        ((pos.x >= `TOWER_MID_OUTLINE_X0 && pos.x < `TOWER_RIGHT_SHAFT_X0) ||
                         (pos.x >= `TOWER_RIGHT_OUTLINE_X0 && pos.x < `TOWER_RIGHT_BLDG_X0));

    assign in_left_shaft  = in_frame_rows && pos.x >= `TOWER_LEFT_SHAFT_X0 &&
                            pos.x < `TOWER_MID_OUTLINE_X0;
    assign in_right_shaft = in_frame_rows && pos.x >= `TOWER_RIGHT_SHAFT_X0 &&
                            pos.x < `TOWER_RIGHT_OUTLINE_X0;

    // Only meaningful below the top sky
    assign floor_rel  = pos.y - coord_t'(`TOWER_TOP_BUF);
    assign floor_band = floor_rel / coord_t'(`TOWER_FLOOR_H);

    always_comb begin
        region_d = GRASS;
        if (!enable) begin
            region_d = BLANK;
        end else if (side_sky || pos.y < `TOWER_TOP_BUF) begin
            region_d = SKY;
        end else if (in_left_bldg || in_right_bldg) begin
            // Ground floor band also covers the rows under the frame
            if (floor_band >= coord_t'(5) || floor_band[0]) begin
                region_d = FLOOR_LIGHT;
            end else begin
                region_d = FLOOR_DARK;
            end
        end else if (in_outline) begin
            region_d = OUTLINE;
        end else if (in_left_shaft) begin
            region_d = LEFT_SHAFT;
        end else if (in_right_shaft) begin
            region_d = RIGHT_SHAFT;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            region <= BLANK;
        end else begin
            region <= region_d;
        end
    end

    region_code_valid: assert property (@(posedge clk) disable iff (rst)
        region inside {BLANK, SKY, FLOOR_DARK, FLOOR_LIGHT, OUTLINE,
                       LEFT_SHAFT, RIGHT_SHAFT, GRASS});

endmodule

`default_nettype wire

// ==== logic/shaft_painter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "tower_settings.svh"

module shaft_painter
    import tower_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,
    input  wire pixel_pos_t pos,
    input  wire sim_state_e sim_state,
    input  wire logic [3:0] level,
    output rgb_t            shaft_rgb
);

    logic [3:0] level_sat;
    coord_t     half_offset;
    coord_t     cab_top;
    logic       in_idle_cab;
    logic       in_run_cab;
    logic       in_stop_box;
    rgb_t       shaft_rgb_d;

    assign level_sat = (level > 4'(`TOWER_TOP_LEVEL)) ? 4'(`TOWER_TOP_LEVEL) : level;

    // Floor height is odd, so every second level picks up the spare row
    assign half_offset = coord_t'(level_sat) * coord_t'(`TOWER_HALF_FLOOR_H) +
                         coord_t'(level_sat[3:1]);

    // Ground-floor cab top is one floor above the bottom of the frame
    assign cab_top = coord_t'(`TOWER_V_ACTIVE - `TOWER_TOP_BUF - `TOWER_FLOOR_H) -
                     half_offset;

    assign in_run_cab  = pos.y >= cab_top &&
                         pos.y < cab_top + coord_t'(`TOWER_FLOOR_H);
    assign in_idle_cab = pos.y >= `TOWER_V_ACTIVE - `TOWER_TOP_BUF - `TOWER_CAB_H;

    assign in_stop_box = pos.x >= `TOWER_STOP_X0 && pos.x <= `TOWER_STOP_X1 &&
                         pos.y >= `TOWER_STOP_Y0 && pos.y <= `TOWER_STOP_Y1;

    always_comb begin
        case (sim_state)
            SIM_IDLE: begin
                shaft_rgb_d = in_idle_cab ? CAB_RGB : SHAFT_RGB;
            end
            SIM_RUN: begin
                shaft_rgb_d = in_run_cab ? CAB_RGB : SHAFT_RGB;
            end
            default: begin
                shaft_rgb_d = in_stop_box ? RED_RGB : BLACK_RGB;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            shaft_rgb <= BLACK_RGB;
        end else begin
            shaft_rgb <= shaft_rgb_d;
        end
    end

    // A running cab never shows below the last shaft row
    cab_within_shaft: assert property (@(posedge clk) disable iff (rst)
        (shaft_rgb == CAB_RGB && $past(sim_state) == SIM_RUN) |->
            $past(pos.y) < `TOWER_V_ACTIVE - `TOWER_TOP_BUF);

endmodule

`default_nettype wire

// ==== logic/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor
    import tower_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire region_e region,
    input  wire rgb_t    left_rgb,
    input  wire rgb_t    right_rgb,
    output rgb_t         rgb
);

    rgb_t rgb_d;

    always_comb begin
        case (region)
            BLANK: begin
                rgb_d = BLACK_RGB;
            end
            SKY: begin
                rgb_d = SKY_RGB;
            end
            FLOOR_DARK: begin
                rgb_d = DARK_FLOOR_RGB;
            end
            FLOOR_LIGHT: begin
                rgb_d = LIGHT_FLOOR_RGB;
            end
            OUTLINE: begin
                rgb_d = BLACK_RGB;
            end
            LEFT_SHAFT: begin
                rgb_d = left_rgb;
            end
            RIGHT_SHAFT: begin
                rgb_d = right_rgb;
            end
            GRASS: begin
                rgb_d = GRASS_RGB;
            end
            default: begin
                rgb_d = BLACK_RGB;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rgb <= BLACK_RGB;
        end else begin
            rgb <= rgb_d;
        end
    end

    // Blanking must reach the output whatever the shafts are drawing
    blank_gives_black: assert property (@(posedge clk) disable iff (rst)
        region == BLANK |=> rgb == BLACK_RGB);

endmodule

`default_nettype wire

// ==== logic/tower_pixel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tower_pixel_gen
    import tower_pkg::*;
(
    input  wire logic         clk,
    input  wire logic         rst,
    input  wire logic         enable,
    input  wire pixel_pos_t   pos,
    input  wire sim_state_e   sim_state,
    input  wire dest_levels_t destination,
    output rgb_t              rgb
);

    // Stage 1 results
    region_e region;
    rgb_t    left_rgb;
    rgb_t    right_rgb;

    backdrop_classifier u_classifier (
        .clk    (clk),
        .rst    (rst),
        .enable (enable),
        .pos    (pos),
        .region (region)
    );

    shaft_painter u_left_shaft (
        .clk       (clk),
        .rst       (rst),
        .pos       (pos),
        .sim_state (sim_state),
        .level     (destination.left_level),
        .shaft_rgb (left_rgb)
    );

    shaft_painter u_right_shaft (
        .clk       (clk),
        .rst       (rst),
        .pos       (pos),
        .sim_state (sim_state),
        .level     (destination.right_level),
        .shaft_rgb (right_rgb)
    );

    // Stage 2
    pixel_compositor u_compositor (
        .clk       (clk),
        .rst       (rst),
        .region    (region),
        .left_rgb  (left_rgb),
        .right_rgb (right_rgb),
        .rgb       (rgb)
    );

endmodule

`default_nettype wire

// ==== tb/tb_tower_pixel_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_tower_pixel_gen
    import tower_pkg::*;
();

    logic         clk;
    logic         rst;
    logic         rst_next;
    logic         enable;
    pixel_pos_t   pos;
    sim_state_e   sim_state;
    dest_levels_t destination;
    rgb_t         rgb;

    rgb_t        expected_q[$];
    int          errors;
    int          checks;
    logic [31:0] rnd;

    // Columns and rows on each side of every picture edge
    int edge_x[19] = '{19, 20, 209, 210, 294, 295, 299, 300, 304, 305,
                       339, 340, 394, 395, 404, 405, 619, 620, 639};
    int edge_y[14] = '{0, 14, 15, 89, 90, 199, 200, 259, 260, 394,
                       395, 464, 465, 479};

    tower_pixel_gen dut (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .pos         (pos),
        .sim_state   (sim_state),
        .destination (destination),
        .rgb         (rgb)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic rgb_t shaft_colour(input int x, input int y,
                                          input logic [1:0] st, input logic [3:0] lvl);
        int l;
        int top;
        l = (lvl > 10) ? 10 : int'(lvl);
        top = 390 - (l * 75) / 2;
        if (st == 2'd0) return (y >= 395) ? CAB_RGB : SHAFT_RGB;
        if (st == 2'd1) return (y >= top && y <= top + 74) ? CAB_RGB : SHAFT_RGB;
        if (x >= 300 && x <= 339 && y >= 200 && y <= 259) return RED_RGB;
        return BLACK_RGB;
    endfunction

    function automatic rgb_t model_pixel(input logic en, input int x, input int y,
                                         input logic [1:0] st, input logic [7:0] d);
        int band;
        if (!en) return BLACK_RGB;
        if (x < 20 || (x >= 620 && y < 465) || y < 15) return SKY_RGB;
        if ((x >= 20 && x <= 209) || (x >= 405 && x <= 619)) begin
            band = (y - 15) / 75;
            if (band > 5) band = 5;
            return (band % 2 == 0) ? DARK_FLOOR_RGB : LIGHT_FLOOR_RGB;
        end
        if (y <= 464) begin
            if ((x >= 295 && x <= 304) || (x >= 395 && x <= 404)) return BLACK_RGB;
            if (x >= 210 && x <= 294) return shaft_colour(x, y, st, d[7:4]);
            if (x >= 305 && x <= 394) return shaft_colour(x, y, st, d[3:0]);
        end
        return GRASS_RGB;
    endfunction

    // Output checked two cycles behind the pixel driven here
    task automatic drive_pixel(input logic en, input int x, input int y,
                               input logic [1:0] st, input logic [7:0] d);
        rgb_t exp;
        @(posedge clk);
        #0.5;
        if (expected_q.size() == 2) begin
            exp = expected_q.pop_front();
            checks++;
            assert (rgb == exp) else begin
                $display("Mismatch at %t: rgb got %h expected %h", $realtime, rgb, exp);
                errors++;
            end
        end
        rst         = rst_next;
        enable      = en;
        pos.x       = coord_t'(x);
        pos.y       = coord_t'(y);
        sim_state   = sim_state_e'(st);
        destination = d;
        expected_q.push_back(rst ? BLACK_RGB : model_pixel(en, x, y, st, d));
    endtask

    task automatic sweep_edges(input logic en, input logic [1:0] st, input logic [7:0] d);
        foreach (edge_x[i]) begin
            foreach (edge_y[j]) begin
                drive_pixel(en, edge_x[i], edge_y[j], st, d);
            end
        end
    endtask

    initial begin
        int n;
        $timeformat(-9, 1, " ns", 0);
        clk = 1'b0;
        rst = 1'b1;
        rst_next = 1'b1;
        enable = 1'b0;
        pos = '0;
        sim_state = SIM_IDLE;
        destination = '0;
        errors = 0;
        checks = 0;
        rnd = 32'd9686;
        // Output is black from the first reset edge on
        expected_q.push_back(BLACK_RGB);
        expected_q.push_back(BLACK_RGB);

        repeat (3) drive_pixel(1'b1, 100, 100, 2'd0, 8'h00);
        rst_next = 1'b0;
        drive_pixel(1'b0, 100, 100, 2'd0, 8'h00);

        n = 0;
        while (rgb != SKY_RGB && n < 8) begin
            drive_pixel(1'b1, 5, 5, 2'd0, 8'h00);
            n++;
        end
        if (rgb != SKY_RGB) begin
            $display("Error: timed out waiting for the first sky pixel at the output");
            errors++;
        end

        sweep_edges(1'b0, 2'd1, 8'h55);
        sweep_edges(1'b1, 2'd0, 8'h00);
        sweep_edges(1'b1, 2'd2, 8'h3C);
        sweep_edges(1'b1, 2'd3, 8'hF1);

        // Full shaft columns at each level with differing nibbles
        for (int lvl = 0; lvl < 16; lvl++) begin
            for (int y = 0; y < 480; y++) begin
                drive_pixel(1'b1, 250, y, 2'd1, {4'(lvl), 4'(15 - lvl)});
                drive_pixel(1'b1, 350, y, 2'd1, {4'(lvl), 4'(15 - lvl)});
            end
            sweep_edges(1'b1, 2'd1, {4'(15 - lvl), 4'(lvl)});
        end

        repeat (4000) begin
            rnd = next_random(rnd);
            if (rnd[19]) begin
                drive_pixel(rnd[31:30] != 2'd0, edge_x[rnd[4:0] % 19], edge_y[rnd[9:5] % 14],
                            rnd[21:20], rnd[29:22]);
            end else begin
                drive_pixel(rnd[31:30] != 2'd0, int'(rnd[15:0] % 640), int'(rnd[31:16] % 480),
                            rnd[21:20], rnd[29:22]);
            end
        end

        repeat (2) drive_pixel(1'b0, 0, 0, 2'd0, 8'h00);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tower_pixel_gen.f ====
+incdir+include
logic/tower_pkg.sv
logic/backdrop_classifier.sv
logic/shaft_painter.sv
logic/pixel_compositor.sv
logic/tower_pixel_gen.sv
tb/tb_tower_pixel_gen.sv

// ==== Bender.yml ====
package:
  name: tower_pixel_gen

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/tower_pkg.sv
      - logic/backdrop_classifier.sv
      - logic/shaft_painter.sv
      - logic/pixel_compositor.sv
      - logic/tower_pixel_gen.sv
  - target: test
    files:
      - tb/tb_tower_pixel_gen.sv
